// File: hdl/rob_pkg.sv
package rob_pkg;

    localparam int ROB_TAG_W = 5;                // Up to 32 entries

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Exception cause reported with the EPC
    typedef enum logic [1:0] {
        CAUSE_ILLEGAL  = 2'd0,                   // Decoded illegal opcode
        CAUSE_DIV      = 2'd1,                   // Divide fault
        CAUSE_ACCESS   = 2'd2,                   // Load/store access fault
        CAUSE_MISALIGN = 2'd3                    // Misaligned address
    } rob_cause_e;

    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,                      // Register result, possibly none
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2,
        KIND_MRET   = 2'd3
    } rob_kind_e;

    // Result word, read according to the entry kind
    typedef union packed {
        logic [31:0] wb_data;                    // Write data or store address
        logic [31:0] target;                     // Branch redirect PC
    } rob_value_u;

    typedef struct packed {
        logic       valid;
        logic       done;                        // Result present
        logic       exc;
        rob_cause_e cause;
        rob_kind_e  kind;
        logic       reg_write;
        logic [4:0] dest;
        logic [2:0] funct3;
        logic       mispredict;
        logic [31:0] pc;
        rob_value_u value;
    } rob_entry_t;

    // One completion from an execution unit
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] data;
        logic        exc;
        rob_cause_e  cause;
        logic        mispredict;                 // Branches only
    } rob_cpl_t;

    // One retired instruction
    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic [4:0]  dest;
        logic [2:0]  funct3;
        logic [31:0] data;                       // Write data or store address
        logic [31:0] pc;
    } rob_commit_t;

endpackage

// File: hdl/rob_dispatch.sv
`timescale 1ns/1ps

module rob_dispatch (
    input  logic [31:0]         dispatch_inst,
    input  logic [31:0]         dispatch_pc,
    output rob_pkg::rob_entry_t entry
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;

    logic [6:0]         opcode;
    logic [4:0]         rd;
    logic               legal;
    rob_pkg::rob_kind_e kind;

    assign opcode = dispatch_inst[6:0];
    assign rd     = dispatch_inst[11:7];

    always_comb begin
        legal = 1'b1;
        kind  = rob_pkg::KIND_REG;
        if (dispatch_inst == MRET_WORD) begin     // Checked before SYSTEM
            kind = rob_pkg::KIND_MRET;
        end else begin
            case (opcode)
                OP_STORE:  kind = rob_pkg::KIND_STORE;
                OP_BRANCH: kind = rob_pkg::KIND_BRANCH;
                OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                OP_LOAD, OP_IMM, OP_OP, OP_SYSTEM: begin
                    kind = rob_pkg::KIND_REG;
                end
                default:   legal = 1'b0;
            endcase
        end
    end

    always_comb begin
        entry            = '0;
        entry.valid      = 1'b1;
        entry.done       = !legal || (kind == rob_pkg::KIND_MRET);   // Nothing to execute
        entry.exc        = !legal;
        entry.cause      = rob_pkg::CAUSE_ILLEGAL;
        entry.kind       = kind;
        entry.reg_write  = legal && (kind == rob_pkg::KIND_REG) && (rd != 5'd0);
        entry.dest       = rd;
        entry.funct3     = dispatch_inst[14:12];
        entry.mispredict = 1'b0;
        entry.pc         = dispatch_pc;
    end

endmodule

// File: hdl/rob_buffer.sv
`timescale 1ns/1ps

module rob_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc_valid,
    input  rob_pkg::rob_entry_t alloc_entry,
    output logic                alloc_ready,
    output rob_pkg::rob_tag_t   alloc_tag,
    input  rob_pkg::rob_cpl_t   cpl_alu,
    input  rob_pkg::rob_cpl_t   cpl_muldiv,
    input  rob_pkg::rob_cpl_t   cpl_lsu,
    output rob_pkg::rob_entry_t head_entry,
    output logic                head_valid,
    input  logic                pop,
    input  logic                flush
);

    localparam int PTR_W = $clog2(ROB_DEPTH);

    rob_pkg::rob_entry_t entries_q [ROB_DEPTH];
    rob_pkg::rob_cpl_t   cpls      [3];
    logic [PTR_W-1:0]    head_q;
    logic [PTR_W-1:0]    tail_q;
    logic [PTR_W:0]      count_q;                // One extra bit to tell full from empty
    logic                do_alloc;

    // Tag compare against an entry index; tags past the depth never match
    function automatic logic cpl_hit(input rob_pkg::rob_cpl_t c, input int unsigned idx);
        return c.valid && (c.tag == rob_pkg::rob_tag_t'(idx));
    endfunction

    assign cpls[0] = cpl_alu;
    assign cpls[1] = cpl_muldiv;
    assign cpls[2] = cpl_lsu;

    assign alloc_ready = count_q != (PTR_W+1)'(ROB_DEPTH);
    assign do_alloc    = alloc_valid && alloc_ready;
    assign alloc_tag   = rob_pkg::rob_tag_t'(tail_q);     // Tag names the tail slot

    assign head_valid = count_q != '0;
    assign head_entry = entries_q[head_q];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries_q[i] <= '0;
            end
        end else begin
            // All three ports land in parallel, never on the same tag
            for (int i = 0; i < ROB_DEPTH; i++) begin
                for (int p = 0; p < 3; p++) begin
                    if (entries_q[i].valid && cpl_hit(cpls[p], i)) begin
                        entries_q[i].done          <= 1'b1;
                        entries_q[i].exc           <= cpls[p].exc;
                        entries_q[i].cause         <= cpls[p].cause;
                        entries_q[i].mispredict    <= cpls[p].mispredict;
                        entries_q[i].value.wb_data <= cpls[p].data;
                    end
                end
            end

            if (do_alloc) begin
                entries_q[tail_q] <= alloc_entry;
                tail_q            <= tail_q + 1'b1;   // Wraps, depth is a power of two
            end

            if (pop) begin
                entries_q[head_q] <= '0;
                head_q            <= head_q + 1'b1;
            end

            case ({do_alloc, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;      // Both or neither
            endcase
        end
    end

endmodule

// File: hdl/rob_commit.sv
`timescale 1ns/1ps

module rob_commit (
    input  logic                 clk,
    input  logic                 reset,
    input  rob_pkg::rob_entry_t  head_entry,
    input  logic                 head_valid,
    output logic                 pop,
    output logic                 flush,
    output logic                 commit_valid,
    output rob_pkg::rob_commit_t commit,
    input  logic                 commit_ready,
    output logic                 exception_valid,
    output logic [31:0]          epc,
    output rob_pkg::rob_cause_e  exc_cause,
    output logic                 mret_valid,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc
);

    logic head_ready;
    logic special;                               // Head ends in a pulse and a flush
    logic room;
    logic take;
    logic load;

    assign head_ready = head_valid && head_entry.done;
    assign special    = head_entry.exc
                     || (head_entry.kind == rob_pkg::KIND_MRET)
                     || (head_entry.kind == rob_pkg::KIND_BRANCH && head_entry.mispredict);
    assign room       = !commit_valid || commit_ready;

    // Pulses wait for an empty output so they follow earlier commits
    assign take  = head_ready && (special ? !commit_valid : room);
    assign flush = take && special;
    assign pop   = take && !special;
    assign load  = pop && (head_entry.kind != rob_pkg::KIND_BRANCH);   // Good branches retire silently

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid    <= 1'b0;
            exception_valid <= 1'b0;
            mret_valid      <= 1'b0;
            redirect_valid  <= 1'b0;
        end else begin
            if (load) begin
                commit_valid <= 1'b1;
            end else if (commit_ready) begin
                commit_valid <= 1'b0;
            end
            exception_valid <= flush && head_entry.exc;
            mret_valid      <= flush && !head_entry.exc && (head_entry.kind == rob_pkg::KIND_MRET);
            redirect_valid  <= flush && !head_entry.exc && (head_entry.kind != rob_pkg::KIND_MRET);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            commit.reg_write <= head_entry.reg_write;
            commit.mem_write <= head_entry.kind == rob_pkg::KIND_STORE;
            commit.dest      <= head_entry.dest;
            commit.funct3    <= head_entry.funct3;
            commit.data      <= head_entry.value.wb_data;
            commit.pc        <= head_entry.pc;
        end
        if (flush) begin
            epc         <= head_entry.pc;        // Precise EPC of the faulting entry
            exc_cause   <= head_entry.cause;
            redirect_pc <= head_entry.value.target;
        end
    end

endmodule

// File: hdl/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  logic [31:0]          dispatch_inst,
    input  logic [31:0]          dispatch_pc,
    output logic                 dispatch_ready,
    output rob_pkg::rob_tag_t    dispatch_tag,
    input  rob_pkg::rob_cpl_t    cpl_alu,
    input  rob_pkg::rob_cpl_t    cpl_muldiv,
    input  rob_pkg::rob_cpl_t    cpl_lsu,
    output logic                 commit_valid,
    output rob_pkg::rob_commit_t commit,
    input  logic                 commit_ready,
    output logic                 exception_valid,
    output logic [31:0]          epc,
    output rob_pkg::rob_cause_e  exc_cause,
    output logic                 mret_valid,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc
);

    rob_pkg::rob_entry_t new_entry;
    rob_pkg::rob_entry_t head_entry;
    logic                head_valid;
    logic                pop;
    logic                flush;

    rob_dispatch dispatch_i (
        .dispatch_inst (dispatch_inst),
        .dispatch_pc   (dispatch_pc),
        .entry         (new_entry)
    );

    rob_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) buffer_i (
        .clk         (clk),
        .reset       (reset),
        .alloc_valid (dispatch_valid),
        .alloc_entry (new_entry),
        .alloc_ready (dispatch_ready),
        .alloc_tag   (dispatch_tag),
        .cpl_alu     (cpl_alu),
        .cpl_muldiv  (cpl_muldiv),
        .cpl_lsu     (cpl_lsu),
        .head_entry  (head_entry),
        .head_valid  (head_valid),
        .pop         (pop),
        .flush       (flush)
    );

    rob_commit commit_i (
        .clk             (clk),
        .reset           (reset),
        .head_entry      (head_entry),
        .head_valid      (head_valid),
        .pop             (pop),
        .flush           (flush),
        .commit_valid    (commit_valid),
        .commit          (commit),
        .commit_ready    (commit_ready),
        .exception_valid (exception_valid),
        .epc             (epc),
        .exc_cause       (exc_cause),
        .mret_valid      (mret_valid),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD  = 50,             // 100 ns clock
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;                         // Released with the stimulus delay
    end

endmodule

// File: bench/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    localparam int DEPTH   = 8;
    localparam int NROWS   = 21;
    localparam int NGRP    = 5;
    localparam int GRP_END [NGRP] = '{8, 12, 15, 18, 21};   // End of each dispatch group
    localparam int TIMEOUT = 50 * NROWS;

    typedef enum int {EV_COMMIT, EV_EXC, EV_MRET, EV_REDIRECT, EV_SILENT} event_e;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [1:0]  port;                       // ALU, MUL/DIV, LSU, or 3 for born done
        logic [31:0] data;
        logic        exc;
        logic [1:0]  cause;
        logic        mis;
    } row_t;

    localparam row_t TABLE [NROWS] = '{
        '{32'h0050_0093, 32'h100, 2'd0, 32'd5,          1'b0, 2'd0, 1'b0},  // addi x1
        '{32'h0010_8133, 32'h104, 2'd0, 32'd10,         1'b0, 2'd0, 1'b0},  // add x2
        '{32'h0000_0013, 32'h108, 2'd0, 32'd0,          1'b0, 2'd0, 1'b0},  // Write to x0
        '{32'h0020_A423, 32'h10c, 2'd2, 32'h0000_000d,  1'b0, 2'd0, 1'b0},  // sw
        '{32'h0020_8463, 32'h110, 2'd0, 32'h0000_0118,  1'b0, 2'd0, 1'b0},  // beq, predicted
        '{32'h0000_A183, 32'h114, 2'd2, 32'hcafe_0000,  1'b0, 2'd0, 1'b0},  // lw x3
        '{32'h0220_83B3, 32'h118, 2'd1, 32'd50,         1'b0, 2'd0, 1'b0},  // mul x7
        '{32'h1234_5237, 32'h11c, 2'd0, 32'h1234_5000,  1'b0, 2'd0, 1'b0},  // lui x4
        '{32'h0000_1297, 32'h200, 2'd0, 32'h0000_1200,  1'b0, 2'd0, 1'b0},  // auipc x5
        '{32'h0200_C433, 32'h204, 2'd1, 32'd0,          1'b1, rob_pkg::CAUSE_DIV, 1'b0},
        '{32'h0010_8133, 32'h208, 2'd0, 32'd1,          1'b0, 2'd0, 1'b0},  // Discarded
        '{32'h0020_A423, 32'h20c, 2'd2, 32'd4,          1'b0, 2'd0, 1'b0},  // Discarded
        '{32'h0100_036F, 32'h300, 2'd0, 32'h0000_0304,  1'b0, 2'd0, 1'b0},  // jal x6
        '{32'h0000_0000, 32'h304, 2'd3, 32'd0,          1'b0, 2'd0, 1'b0},  // Illegal
        '{32'h0050_0093, 32'h308, 2'd0, 32'd5,          1'b0, 2'd0, 1'b0},  // Discarded
        '{32'h0000_A183, 32'h400, 2'd2, 32'h0000_0011,  1'b0, 2'd0, 1'b0},  // lw x3
        '{32'h0020_9463, 32'h404, 2'd0, 32'h0000_0480,  1'b0, 2'd0, 1'b1},  // bne, mispredicted
        '{32'h0010_8133, 32'h408, 2'd0, 32'd3,          1'b0, 2'd0, 1'b0},  // Discarded
        '{32'h0050_0093, 32'h500, 2'd0, 32'd7,          1'b0, 2'd0, 1'b0},  // addi x1
        '{32'h3020_0073, 32'h504, 2'd3, 32'd0,          1'b0, 2'd0, 1'b0},  // mret
        '{32'h0010_8133, 32'h508, 2'd0, 32'd9,          1'b0, 2'd0, 1'b0}   // Discarded
    };

    logic                 clk, reset;
    logic                 dispatch_valid, dispatch_ready, commit_valid, commit_ready;
    logic                 exception_valid, mret_valid, redirect_valid;
    logic [31:0]          dispatch_inst, dispatch_pc, epc, redirect_pc;
    rob_pkg::rob_tag_t    dispatch_tag;
    rob_pkg::rob_cpl_t    cpl_alu, cpl_muldiv, cpl_lsu;
    rob_pkg::rob_commit_t commit;
    rob_pkg::rob_cause_e  exc_cause;
    rob_pkg::rob_tag_t    tags [NROWS];
    logic [15:0]          lfsr = 16'd75;
    int                   exp_idx = 0;          // Next row the model expects to retire
    int                   exp_tail = 0;         // Tail slot the next dispatch should get
    int                   cycles = 0;

    clk_gen clk_gen_i (.clk(clk), .reset(reset));

    rob_top #(.ROB_DEPTH(DEPTH)) dut_i (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input logic [79:0] got, input logic [79:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s: got %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // Taps 16, 14, 13, 11
            lfsr = {lfsr[14:0], fb};
            v    = {v[6:0], fb};
        end
        return v;
    endfunction

    function automatic logic is_legal(input logic [6:0] op);
        case (op)
            7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h13, 7'h33, 7'h73, 7'h23, 7'h63: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // What the head does when this row reaches it
    function automatic event_e retire_event(input int r);
        if (TABLE[r].inst == 32'h3020_0073) return EV_MRET;
        if (!is_legal(TABLE[r].inst[6:0]) || TABLE[r].exc) return EV_EXC;
        if (TABLE[r].inst[6:0] == 7'h63) return TABLE[r].mis ? EV_REDIRECT : EV_SILENT;
        return EV_COMMIT;
    endfunction

    function automatic int group_end(input int r);
        for (int g = 0; g < NGRP; g++) begin
            if (GRP_END[g] > r) return GRP_END[g];
        end
        return NROWS;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
        cpl_alu      = '0;
        cpl_muldiv   = '0;
        cpl_lsu      = '0;
        commit_ready = rand_bits(2) != 2'd0;     // Low about one cycle in four
    endtask

    task automatic drive_cpl(input int r);
        rob_pkg::rob_cpl_t c;
        c.valid      = 1'b1;
        c.tag        = tags[r];
        c.data       = TABLE[r].data;
        c.exc        = TABLE[r].exc;
        c.cause      = rob_pkg::rob_cause_e'(TABLE[r].cause);
        c.mispredict = TABLE[r].mis;
        case (TABLE[r].port)
            2'd0:    cpl_alu = c;
            2'd1:    cpl_muldiv = c;
            default: cpl_lsu = c;
        endcase
    endtask

    // Reference model checked where a commit is taken or a pulse is seen
    always @(negedge clk) begin
        int r;
        int got;
        rob_pkg::rob_commit_t exp_c;
        if (!reset && (exception_valid || mret_valid || redirect_valid
                       || (commit_valid && commit_ready))) begin
            r = exp_idx;
            if (r >= NROWS) abort_run("a retirement was seen after the last table row");
            got = exception_valid ? EV_EXC : mret_valid ? EV_MRET
                : redirect_valid ? EV_REDIRECT : EV_COMMIT;
            check(got, retire_event(r), $sformatf("retirement kind of row %0d", r));
            case (retire_event(r))
                EV_COMMIT: begin
                    exp_c.reg_write = TABLE[r].inst[6:0] != 7'h23 && TABLE[r].inst[11:7] != 0;
                    exp_c.mem_write = TABLE[r].inst[6:0] == 7'h23;
                    exp_c.dest      = TABLE[r].inst[11:7];
                    exp_c.funct3    = TABLE[r].inst[14:12];
                    exp_c.data      = TABLE[r].data;
                    exp_c.pc        = TABLE[r].pc;
                    check(commit, exp_c, $sformatf("commit of row %0d", r));
                    check(dispatch_ready, 1'b1, "dispatch_ready after a commit");
                end
                EV_EXC: begin
                    check(epc, TABLE[r].pc, "epc");
                    check(exc_cause, is_legal(TABLE[r].inst[6:0]) ? TABLE[r].cause
                                     : rob_pkg::CAUSE_ILLEGAL, "exception cause");
                end
                EV_REDIRECT: check(redirect_pc, TABLE[r].data, "redirect pc");
                default: ;
            endcase
            if (retire_event(r) == EV_COMMIT) begin
                exp_idx = r + 1;
            end else begin
                exp_idx  = group_end(r);         // Flush ends group
                exp_tail = 0;                    // Both pointers cleared
            end
            while (exp_idx < NROWS && retire_event(exp_idx) == EV_SILENT) exp_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) abort_run($sformatf("timeout after %0d cycles", TIMEOUT));
    end

    initial begin
        int first;
        int pick;
        int pending [$];
        dispatch_valid = 1'b0;
        dispatch_inst  = '0;
        dispatch_pc    = '0;
        cpl_alu        = '0;
        cpl_muldiv     = '0;
        cpl_lsu        = '0;
        commit_ready   = 1'b1;
        @(negedge reset);
        check({commit_valid, exception_valid, mret_valid, redirect_valid}, 0,
              "outputs after reset");
        check(dispatch_ready, 1'b1, "dispatch_ready after reset");
        first = 0;
        for (int g = 0; g < NGRP; g++) begin
            for (int r = first; r < GRP_END[g]; r++) begin
                dispatch_valid = 1'b1;
                dispatch_inst  = TABLE[r].inst;
                dispatch_pc    = TABLE[r].pc;
                while (!dispatch_ready) next_cycle();
                check(dispatch_tag, exp_tail, $sformatf("dispatch tag of row %0d", r));
                tags[r] = dispatch_tag;
                if (TABLE[r].port != 2'd3) pending.push_back(r);
                next_cycle();
                exp_tail = (exp_tail + 1) % DEPTH;
            end
            dispatch_valid = 1'b0;
            if (GRP_END[g] - first == DEPTH) begin
                check(dispatch_ready, 1'b0, "dispatch_ready when full");
            end
            while (pending.size() > 0) begin      // Complete in random order
                pick = int'(rand_bits(3)) % pending.size();
                drive_cpl(pending[pick]);
                pending.delete(pick);
                next_cycle();
            end
            while (exp_idx < GRP_END[g]) next_cycle();
            first = GRP_END[g];
        end
        repeat (5) next_cycle();                  // Catch stray retirements
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: rob_top.f
hdl/rob_pkg.sv
hdl/rob_dispatch.sv
hdl/rob_buffer.sv
hdl/rob_commit.sv
hdl/rob_top.sv
bench/clk_gen.sv
bench/rob_tb.sv

// File: Bender.yml
package:
  name: rob_top

sources:
  - hdl/rob_pkg.sv
  - hdl/rob_dispatch.sv
  - hdl/rob_buffer.sv
  - hdl/rob_commit.sv
  - hdl/rob_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/rob_tb.sv
